//--- rtl/rlbp_settings.svh
// RLBP readout settings
// counter, channel and word dimensions shared by all blocks

`ifndef RLBP_SETTINGS_SVH
`define RLBP_SETTINGS_SVH

// frame counter and window bound width
`define CNT_W 12

// sensor control pulse channels
`define NUM_CHAN 7

// comparator bits captured per row
`define ROW_BITS 3

// pixel rows per RLBP word
`define NUM_ROWS 3

// total bits in one RLBP word
`define WORD_BITS 9

`endif

//--- rtl/timing_pkg.sv
// frame timing types
// frame counts, channel vectors and channel positions

`default_nettype none

`include "rlbp_settings.svh"

package timing_pkg;

	typedef logic [`CNT_W-1:0] frame_cnt_t;

	typedef logic [`NUM_CHAN-1:0] chan_vec_t;

	// channel i bound sits at bits [i*CNT_W +: CNT_W]
	typedef logic [`NUM_CHAN*`CNT_W-1:0] chan_bounds_t;

	// positions in chan_vec_t and chan_bounds_t
	typedef enum logic [2:0] {
		vd1      = 3'd0,
		vd2      = 3'd1,
		sw1      = 3'd2,
		sw2      = 3'd3,
		sh       = 3'd4,
		sh_cmp   = 3'd5,
		sh_reset = 3'd6
	} chan_idx_e;

endpackage

`default_nettype wire

//--- rtl/rlbp_pkg.sv
// RLBP datapath types
// captured word, row addressing and sequencer states

`default_nettype none

`include "rlbp_settings.svh"

package rlbp_pkg;

	// row 0 in the low bits, row 2 in the high bits
	typedef logic [`WORD_BITS-1:0] rlbp_word_t;

	typedef logic [$clog2(`NUM_ROWS)-1:0] row_idx_t;

	// one-hot so at most one row shifts per cycle
	typedef logic [`NUM_ROWS-1:0] row_en_t;

	// wide enough to hold WORD_BITS itself
	typedef logic [3:0] bit_idx_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_collect,
		seq_done
	} seq_state_e;

endpackage

`default_nettype wire

//--- rtl/pulse_channel.sv
// pulse channel
// one registered window compare that drives a sensor control pulse

`timescale 1ns/100ps
`default_nettype none

module pulse_channel
	import timing_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire frame_cnt_t count_i,
	input  wire frame_cnt_t start_cnt_i,
	input  wire frame_cnt_t stop_cnt_i,
	output logic            pulse_o
);

	logic in_window;

	// start is inclusive, stop is exclusive
	assign in_window = (count_i >= start_cnt_i) && (count_i < stop_cnt_i);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pulse_o <= 1'b0;
		end else begin
			pulse_o <= in_window;
		end
	end

endmodule

`default_nettype wire

//--- rtl/frame_timer.sv
// frame timer
// frame counter with wrap, seven control pulse windows
// and a one-cycle pixel strobe on the rising edge of sh_cmp

`timescale 1ns/100ps
`default_nettype none

`include "rlbp_settings.svh"

module frame_timer
	import timing_pkg::*;
(
	input  wire               clk,
	input  wire               reset,
	input  wire               start_i,
	input  wire frame_cnt_t   frame_len_i,
	input  wire chan_bounds_t chan_start_i,
	input  wire chan_bounds_t chan_stop_i,
	output chan_vec_t         pulses_o,
	output logic              pxl_strobe_o
);

	frame_cnt_t count_q;
	frame_cnt_t last_cnt;
	logic       sh_cmp_q;

	assign last_cnt = frame_len_i - 1'b1;

	// count held at zero while stopped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count_q <= '0;
		end else if (!start_i || count_q == last_cnt) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
		pulse_channel i_chan (
			.clk         (clk),
			.reset       (reset),
			.count_i     (count_q),
			.start_cnt_i (chan_start_i[i*`CNT_W +: `CNT_W]),
			.stop_cnt_i  (chan_stop_i[i*`CNT_W +: `CNT_W]),
			.pulse_o     (pulses_o[i])
		);
	end

	// sh_cmp rising edge marks a finished pixel compare
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sh_cmp_q     <= 1'b0;
			pxl_strobe_o <= 1'b0;
		end else begin
			sh_cmp_q     <= pulses_o[sh_cmp];
			pxl_strobe_o <= pulses_o[sh_cmp] & ~sh_cmp_q;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rlbp_sequencer.sv
// RLBP sequencer
// counts pixel strobes into three rows of three bits,
// then starts the serializer and waits for start to drop

`timescale 1ns/100ps
`default_nettype none

`include "rlbp_settings.svh"

module rlbp_sequencer
	import rlbp_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  wire   start_i,
	input  wire   pxl_strobe_i,
	output row_en_t row_en_o,
	output logic  load_o,
	output logic  clear_o,
	output logic  rlbp_done_o
);

	localparam row_idx_t last_row = row_idx_t'(`NUM_ROWS - 1);
	localparam bit_idx_t last_bit = bit_idx_t'(`ROW_BITS - 1);

	seq_state_e state_q;
	seq_state_e state_d;
	row_idx_t   row_cnt;
	bit_idx_t   bit_cnt;
	logic       strobe_hit;
	logic       ninth_strobe;

	assign strobe_hit   = (state_q == seq_collect) && pxl_strobe_i;
	assign ninth_strobe = strobe_hit && (row_cnt == last_row) && (bit_cnt == last_bit);

	// capture enable in the strobe cycle itself
	assign row_en_o = strobe_hit ? (row_en_t'(1'b1) << row_cnt) : '0;

	assign rlbp_done_o = (state_q == seq_done);

	always_comb begin
		state_d = state_q;
		case (state_q)
			seq_idle: begin
				if (start_i) begin
					state_d = seq_collect;
				end
			end
			seq_collect: begin
				if (!start_i) begin
					state_d = seq_idle;
				end else if (ninth_strobe) begin
					state_d = seq_done;
				end
			end
			seq_done: begin
				if (!start_i) begin
					state_d = seq_idle;
				end
			end
			default: begin
				state_d = seq_idle;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= seq_idle;
			load_o  <= 1'b0;
			clear_o <= 1'b0;
		end else begin
			state_q <= state_d;
			load_o  <= ninth_strobe;
			// falling start from any active state
			clear_o <= (state_q != seq_idle) && !start_i;
		end
	end

	// bit within the row, then row
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			row_cnt <= '0;
			bit_cnt <= '0;
		end else if (state_q == seq_idle) begin
			row_cnt <= '0;
			bit_cnt <= '0;
		end else if (strobe_hit) begin
			if (bit_cnt == last_bit) begin
				bit_cnt <= '0;
				row_cnt <= row_cnt + 1'b1;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rlbp_capture.sv
// RLBP capture bank
// three row shift registers fed from the comparator bit

`timescale 1ns/100ps
`default_nettype none

`include "rlbp_settings.svh"

module rlbp_capture
	import rlbp_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	input  wire          clear_i,
	input  wire row_en_t row_en_i,
	input  wire          data_i,
	output rlbp_word_t   word_o
);

	logic [`ROW_BITS-1:0] row_q [`NUM_ROWS];

	// newest bit lands in position 0
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < `NUM_ROWS; r++) begin
				row_q[r] <= '0;
			end
		end else begin
			for (int r = 0; r < `NUM_ROWS; r++) begin
				if (clear_i) begin
					row_q[r] <= '0;
				end else if (row_en_i[r]) begin
					row_q[r] <= {row_q[r][`ROW_BITS-2:0], data_i};
				end
			end
		end
	end

	// row 0 in the lowest field
	always_comb begin
		for (int r = 0; r < `NUM_ROWS; r++) begin
			word_o[r*`ROW_BITS +: `ROW_BITS] = row_q[r];
		end
	end

endmodule

`default_nettype wire

//--- rtl/rlbp_serializer.sv
// RLBP serializer
// sends the captured word LSB first, one bit per cycle,
// then holds done until cleared

`timescale 1ns/100ps
`default_nettype none

`include "rlbp_settings.svh"

module rlbp_serializer
	import rlbp_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             load_i,
	input  wire             clear_i,
	input  wire rlbp_word_t word_i,
	output logic            ser_bit_o,
	output logic            ser_valid_o,
	output logic            ser_done_o
);

	rlbp_word_t shift_q;
	bit_idx_t   remain_q;

	assign ser_valid_o = (remain_q != '0);
	assign ser_bit_o   = ser_valid_o & shift_q[0];

	always_ff @(posedge clk) begin
		if (load_i) begin
			shift_q <= word_i;
		end else if (ser_valid_o) begin
			shift_q <= shift_q >> 1;
		end
	end

	// bits still to send and the done flag that follows the last one
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			remain_q   <= '0;
			ser_done_o <= 1'b0;
		end else if (clear_i) begin
			remain_q   <= '0;
			ser_done_o <= 1'b0;
		end else if (load_i) begin
			remain_q   <= bit_idx_t'(`WORD_BITS);
			ser_done_o <= 1'b0;
		end else if (ser_valid_o) begin
			remain_q <= remain_q - 1'b1;
			if (remain_q == bit_idx_t'(1)) begin
				ser_done_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rlbp_top.sv
// RLBP readout controller top
// frame timer drives the sensor pulses and pixel strobe, the
// sequencer fills the capture bank and the serializer sends it out

`timescale 1ns/100ps
`default_nettype none

module rlbp_top
	import timing_pkg::*;
	import rlbp_pkg::*;
(
	input  wire               clk,
	input  wire               reset,
	input  wire               start_i,
	input  wire               data_i,
	input  wire frame_cnt_t   frame_len_i,
	input  wire chan_bounds_t chan_start_i,
	input  wire chan_bounds_t chan_stop_i,
	output chan_vec_t         pulses_o,
	output logic              rlbp_done_o,
	output logic              ser_bit_o,
	output logic              ser_valid_o,
	output logic              ser_done_o
);

	logic       pxl_strobe;
	row_en_t    row_en;
	logic       load;
	logic       clear;
	rlbp_word_t word;

	frame_timer i_timer (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.frame_len_i  (frame_len_i),
		.chan_start_i (chan_start_i),
		.chan_stop_i  (chan_stop_i),
		.pulses_o     (pulses_o),
		.pxl_strobe_o (pxl_strobe)
	);

	rlbp_sequencer i_seq (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.pxl_strobe_i (pxl_strobe),
		.row_en_o     (row_en),
		.load_o       (load),
		.clear_o      (clear),
		.rlbp_done_o  (rlbp_done_o)
	);

	// comparator bit is sampled in the strobe cycle
	rlbp_capture i_capture (
		.clk      (clk),
		.reset    (reset),
		.clear_i  (clear),
		.row_en_i (row_en),
		.data_i   (data_i),
		.word_o   (word)
	);

	rlbp_serializer i_ser (
		.clk         (clk),
		.reset       (reset),
		.load_i      (load),
		.clear_i     (clear),
		.word_i      (word),
		.ser_bit_o   (ser_bit_o),
		.ser_valid_o (ser_valid_o),
		.ser_done_o  (ser_done_o)
	);

endmodule

`default_nettype wire

//--- test/rlbp_props.sv
// RLBP protocol properties
// bound into the sequencer and the serializer

`timescale 1ns/100ps
`default_nettype none

module rlbp_props
	import rlbp_pkg::*;
(
	input wire          clk,
	input wire          reset,
	input wire row_en_t row_en_i,
	input wire          load_i,
	input wire          ser_valid_i,
	input wire          ser_done_i
);

	// at most one row shifts per strobe
	row_en_onehot: assert property (
		@(posedge clk) disable iff (reset) $onehot0(row_en_i)
	) else $error("row enable has more than one bit set");

	// load is a single-cycle pulse
	load_single: assert property (
		@(posedge clk) disable iff (reset) load_i |=> !load_i
	) else $error("load stayed high for two cycles in a row");

	// serial bits and completion never overlap
	valid_done_excl: assert property (
		@(posedge clk) disable iff (reset) !(ser_valid_i && ser_done_i)
	) else $error("serial valid and serial done are high together");

endmodule

`default_nettype wire

//--- test/rlbp_tb.sv
// RLBP readout testbench
// runs each table case through pulse timing, capture and serial readout

`timescale 1ns/100ps
`default_nettype none

`include "rlbp_settings.svh"

module rlbp_tb
	import timing_pkg::*;
	import rlbp_pkg::*;
();

	localparam int n_cases = 3;

	// frame length, channel windows, data bits in send order and expected word per case
	// a random case draws its bits from the LCG and predicts the word from them
	int         case_len   [n_cases] = '{40, 24, 32};
	int         case_start [n_cases][`NUM_CHAN] = '{
		'{1, 3, 6, 10, 14, 20, 30},
		'{2, 2, 5, 8, 10, 12, 16},
		'{1, 4, 6, 9, 12, 17, 25}
	};
	int         case_stop  [n_cases][`NUM_CHAN] = '{
		'{5, 9, 12, 18, 22, 24, 40},
		'{4, 6, 9, 11, 14, 13, 23},
		'{2, 12, 8, 20, 16, 21, 31}
	};
	rlbp_word_t case_data  [n_cases] = '{9'h11d, 9'h000, 9'h1a6};
	bit         case_rand  [n_cases] = '{1'b0, 1'b1, 1'b0};
	rlbp_word_t case_word  [n_cases] = '{9'h075, 9'h000, 9'h0cb};

	logic         clk;
	logic         reset;
	logic         start_i;
	logic         data_i;
	frame_cnt_t   frame_len_i;
	chan_bounds_t chan_start_i;
	chan_bounds_t chan_stop_i;
	chan_vec_t    pulses_o;
	logic         rlbp_done_o;
	logic         ser_bit_o;
	logic         ser_valid_o;
	logic         ser_done_o;

	int          exp_len;
	int          exp_width   [`NUM_CHAN];
	int          high_cnt    [`NUM_CHAN];
	int          since_rise  [`NUM_CHAN];
	bit          seen_rise   [`NUM_CHAN];
	int          width_seen  [`NUM_CHAN];
	int          period_seen [`NUM_CHAN];
	logic [31:0] lcg_state = 32'hd2ad;

	rlbp_top i_dut (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.data_i       (data_i),
		.frame_len_i  (frame_len_i),
		.chan_start_i (chan_start_i),
		.chan_stop_i  (chan_stop_i),
		.pulses_o     (pulses_o),
		.rlbp_done_o  (rlbp_done_o),
		.ser_bit_o    (ser_bit_o),
		.ser_valid_o  (ser_valid_o),
		.ser_done_o   (ser_done_o)
	);

	bind rlbp_sequencer rlbp_props i_seq_props (
		.clk         (clk),
		.reset       (reset),
		.row_en_i    (row_en_o),
		.load_i      (load_o),
		.ser_valid_i (1'b0),
		.ser_done_i  (1'b0)
	);

	bind rlbp_serializer rlbp_props i_ser_props (
		.clk         (clk),
		.reset       (reset),
		.row_en_i    ('0),
		.load_i      (load_i),
		.ser_valid_i (ser_valid_o),
		.ser_done_i  (ser_done_o)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// row r takes bits 3r to 3r+2 and the newest one sits lowest
	function automatic rlbp_word_t predict_word(input rlbp_word_t bits);
		rlbp_word_t word;
		word = '0;
		for (int k = 0; k < `WORD_BITS; k++) begin
			word[(k / `ROW_BITS) * `ROW_BITS + (`ROW_BITS - 1 - k % `ROW_BITS)] = bits[k];
		end
		return word;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// channel width and period monitor that idles while start is low
	always @(posedge clk) begin
		for (int c = 0; c < `NUM_CHAN; c++) begin
			if (!start_i) begin
				high_cnt[c]   = 0;
				since_rise[c] = 0;
				seen_rise[c]  = 1'b0;
			end else begin
				since_rise[c]++;
				if (pulses_o[c] && high_cnt[c] == 0) begin
					if (seen_rise[c]) begin
						assert (since_rise[c] == exp_len)
						else mismatch($sformatf("pulses_o[%0d] period", c), since_rise[c], exp_len);
						period_seen[c]++;
					end
					seen_rise[c]  = 1'b1;
					since_rise[c] = 0;
				end
				if (pulses_o[c]) begin
					high_cnt[c]++;
				end else if (high_cnt[c] != 0) begin
					assert (high_cnt[c] == exp_width[c])
					else mismatch($sformatf("pulses_o[%0d] width", c), high_cnt[c], exp_width[c]);
					width_seen[c]++;
					high_cnt[c] = 0;
				end
			end
		end
	end

	task automatic run_case(input int n);
		rlbp_word_t bits;
		rlbp_word_t expect_word;
		rlbp_word_t got_word;
		int         n_sent;
		int         n_valid;
		logic       cmp_q;
		logic       valid_q;
		logic       done_q;

		bits = case_data[n];
		if (case_rand[n]) begin
			for (int k = 0; k < `WORD_BITS; k++) begin
				lcg_state = lcg_next(lcg_state);
				bits[k]   = lcg_state[16];
			end
			expect_word = predict_word(bits);
		end else begin
			expect_word = case_word[n];
		end

		@(posedge clk);
		frame_len_i <= frame_cnt_t'(case_len[n]);
		for (int c = 0; c < `NUM_CHAN; c++) begin
			chan_start_i[c*`CNT_W +: `CNT_W] <= frame_cnt_t'(case_start[n][c]);
			chan_stop_i[c*`CNT_W +: `CNT_W]  <= frame_cnt_t'(case_stop[n][c]);
			exp_width[c]   = case_stop[n][c] - case_start[n][c];
			width_seen[c]  = 0;
			period_seen[c] = 0;
		end
		exp_len = case_len[n];

		// everything stays quiet while start is low
		repeat (8) begin
			@(posedge clk);
			assert (pulses_o == '0) else mismatch("pulses_o", pulses_o, 0);
			assert (!rlbp_done_o) else mismatch("rlbp_done_o", rlbp_done_o, 0);
			assert (!ser_valid_o) else mismatch("ser_valid_o", ser_valid_o, 0);
			assert (!ser_done_o) else mismatch("ser_done_o", ser_done_o, 0);
		end

		start_i  <= 1'b1;
		n_sent   = 0;
		n_valid  = 0;
		cmp_q    = 1'b0;
		valid_q  = 1'b0;
		done_q   = 1'b0;
		got_word = '0;
		do begin
			@(posedge clk);
			// the strobe follows one cycle after sh_cmp rises
			if (pulses_o[sh_cmp] && !cmp_q && n_sent < `WORD_BITS) begin
				data_i <= bits[n_sent];
				n_sent++;
			end
			cmp_q = pulses_o[sh_cmp];
			if (ser_valid_o) begin
				assert (done_q) else abort_run("serial bit seen before rlbp_done_o rose");
				assert (n_valid < `WORD_BITS) else abort_run("ser_valid_o high for over nine cycles");
				got_word[n_valid] = ser_bit_o;
				n_valid++;
			end else if (valid_q) begin
				assert (ser_done_o) else abort_run("ser_done_o did not follow the last serial bit");
			end
			if (ser_done_o) begin
				assert (valid_q) else abort_run("ser_done_o rose without a serial bit before it");
			end
			valid_q = ser_valid_o;
			done_q  = rlbp_done_o;
		end while (!ser_done_o);

		assert (n_sent == `WORD_BITS) else mismatch("sh_cmp rises", n_sent, `WORD_BITS);
		assert (n_valid == `WORD_BITS) else mismatch("ser_valid_o cycles", n_valid, `WORD_BITS);
		assert (got_word == expect_word) else mismatch("ser_bit_o word", got_word, expect_word);

		// completion flags hold until start falls
		repeat (4) begin
			@(posedge clk);
			assert (ser_done_o) else abort_run("ser_done_o dropped while start_i was high");
			assert (rlbp_done_o) else abort_run("rlbp_done_o dropped while start_i was high");
		end
		for (int c = 0; c < `NUM_CHAN; c++) begin
			assert (width_seen[c] > 0 && period_seen[c] > 0)
			else abort_run($sformatf("channel %0d pulse was never fully measured", c));
		end

		start_i <= 1'b0;
		do begin
			@(posedge clk);
		end while (rlbp_done_o || ser_done_o);
	endtask

	initial begin
		int limit;
		limit = 16 + 64;
		for (int n = 0; n < n_cases; n++) begin
			limit += 9 * case_len[n] + 64;
		end
		repeat (limit) @(posedge clk);
		abort_run($sformatf("timeout: test did not finish within %0d cycles", limit));
	end

	initial begin
		reset        = 1'b1;
		start_i      = 1'b0;
		data_i       = 1'b0;
		frame_len_i  = '0;
		chan_start_i = '0;
		chan_stop_i  = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int n = 0; n < n_cases; n++) begin
			run_case(n);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/timing_pkg.sv
rtl/rlbp_pkg.sv
rtl/pulse_channel.sv
rtl/frame_timer.sv
rtl/rlbp_sequencer.sv
rtl/rlbp_capture.sv
rtl/rlbp_serializer.sv
rtl/rlbp_top.sv
test/rlbp_props.sv
test/rlbp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the RLBP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module rlbp_tb -f build.f -o rlbp_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/rlbp_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished"
exit 0
